// ==== rtl/dlx_rx_defs.svh ====
/*
  receive link constants for the 4-lane build
  lanes x block bits must equal one flit beat (flit bits / beats)
  deskew depth must be a power of two, pointers wrap naturally
*/
`default_nettype none

`ifndef DLX_RX_DEFS_SVH
`define DLX_RX_DEFS_SVH

// ------------------------------------------------------------
// link geometry
`define DLX_LANES        4     // lanes in the link
`define DLX_BLOCK_BITS   64    // payload per 66b block
`define DLX_HDR_BITS     2     // sync header width

// ------------------------------------------------------------
// block lock and deskew
`define DLX_LOCK_GOOD    32    // good headers in a row to lock
`define DLX_LOSE_BAD     4     // bad headers in a row to unlock
`define DLX_SLIP_WAIT    4     // beats skipped while gearbox slips
`define DLX_DESKEW_DEPTH 8     // entries per lane fifo

`define DLX_FLIT_BITS    512   // assembled flit
`define DLX_FLIT_BEATS   2     // fifo reads per flit

`endif

`default_nettype wire

// ==== rtl/dlx_lane_pkg.sv ====
/*
  per-lane types, headers and control block codes
  only payload bits [7:0] of a control block carry its type
*/
`include "dlx_rx_defs.svh"
`default_nettype none

package dlx_lane_pkg;

   // 64b/66b sync header, 00 and 11 are invalid
   typedef enum logic [`DLX_HDR_BITS-1:0] {
      HDR_DATA = 2'b01,
      HDR_CTL  = 2'b10
   } hdr_e;

   // control block type byte
   typedef enum logic [7:0] {
      CTL_SYNC   = 8'h1E,
      CTL_TS1    = 8'h2D,
      CTL_DESKEW = 8'h4B   // starts fifo writes
   } ctl_type_e;

   typedef enum logic [1:0] {
      LOCK_HUNT,            // counting good headers
      LOCK_SLIP_WAIT,       // gearbox moving, ignore beats
      LOCK_LOCKED
   } lock_state_e;

   // one registered block, 66 bits
   typedef struct packed {
      logic [`DLX_HDR_BITS-1:0]   hdr;
      logic [`DLX_BLOCK_BITS-1:0] payload;
   } lane_beat_t;

endpackage

`default_nettype wire

// ==== rtl/dlx_link_pkg.sv ====
/*
  link-wide types
  flit is a flat vector, lane n of beat b sits at b*256 + n*64
*/
`include "dlx_rx_defs.svh"
`default_nettype none

package dlx_link_pkg;

   // joint deskew and link bring-up
   typedef enum logic [1:0] {
      LINK_DOWN,      // some lane not locked
      LINK_DESKEW,    // waiting for aligned markers
      LINK_ALIGNED,   // deskew done, still training
      LINK_UP
   } link_state_e;

   // full flit toward the transaction layer
   typedef logic [`DLX_FLIT_BITS-1:0] flit_t;

endpackage

`default_nettype wire

// ==== rtl/dlx_rx_block_lock.sv ====
/*
  one lane of 64b/66b block lock
  input beat is registered once, lock and slip are decided from that copy
  pattern pulses need lock, two cycles after the beat hits the pins
*/
`include "dlx_rx_defs.svh"
`default_nettype none

module dlx_rx_block_lock (
   input  wire                             opt_gckn,
   input  wire                             arst_n,
   input  wire                             rx_valid,
   input  wire [`DLX_HDR_BITS-1:0]         rx_header,
   input  wire [`DLX_BLOCK_BITS-1:0]       rx_data,
   output logic                            rx_slip,       // to gearbox
   output logic                            lock,
   output logic                            pattern_sync,
   output logic                            pattern_ts1,
   output logic                            beat_valid,
   output dlx_lane_pkg::lane_beat_t        beat
);
   import dlx_lane_pkg::*;

   localparam int GOOD_W = $clog2(`DLX_LOCK_GOOD);
   localparam int BAD_W  = $clog2(`DLX_LOSE_BAD);
   localparam int WAIT_W = $clog2(`DLX_SLIP_WAIT);

   lock_state_e       state_q;
   logic [GOOD_W-1:0] good_cnt_q;   // consecutive good while hunting
   logic [BAD_W-1:0]  bad_cnt_q;    // consecutive bad while locked
   logic [WAIT_W-1:0] wait_cnt_q;
   logic              hdr_ok;
   logic              ctl_locked;

   // ------------------------------------------------------------
   // input capture
   always_ff @(posedge opt_gckn or negedge arst_n) begin
      if (!arst_n) begin
         beat_valid <= 1'b0;
      end else begin
         beat_valid <= rx_valid;
      end
   end

   always_ff @(posedge opt_gckn) begin
      beat.hdr     <= rx_header;
      beat.payload <= rx_data;
   end

   assign hdr_ok     = (beat.hdr == HDR_DATA) || (beat.hdr == HDR_CTL);
   assign ctl_locked = beat_valid && (state_q == LOCK_LOCKED) && (beat.hdr == HDR_CTL);
   assign lock       = (state_q == LOCK_LOCKED);

   // ------------------------------------------------------------
   // lock fsm, only advances on valid beats
   always_ff @(posedge opt_gckn or negedge arst_n) begin
      if (!arst_n) begin
         state_q    <= LOCK_HUNT;
         good_cnt_q <= '0;
         bad_cnt_q  <= '0;
         wait_cnt_q <= '0;
         rx_slip    <= 1'b0;
      end else begin
         rx_slip <= 1'b0;                       // single cycle pulse
         if (beat_valid) begin
            case (state_q)
               LOCK_HUNT: begin
                  if (!hdr_ok) begin
                     rx_slip    <= 1'b1;        // shift one bit and retry
                     good_cnt_q <= '0;
                     wait_cnt_q <= '0;
                     state_q    <= LOCK_SLIP_WAIT;
                  end else if (good_cnt_q == GOOD_W'(`DLX_LOCK_GOOD - 1)) begin
                     bad_cnt_q <= '0;
                     state_q   <= LOCK_LOCKED;
                  end else begin
                     good_cnt_q <= good_cnt_q + 1'b1;
                  end
               end
               LOCK_SLIP_WAIT: begin
                  // beats still misaligned here
                  if (wait_cnt_q == WAIT_W'(`DLX_SLIP_WAIT - 1)) begin
                     good_cnt_q <= '0;
                     state_q    <= LOCK_HUNT;
                  end else begin
                     wait_cnt_q <= wait_cnt_q + 1'b1;
                  end
               end
               LOCK_LOCKED: begin
                  if (hdr_ok) begin
                     bad_cnt_q <= '0;           // run broken
                  end else if (bad_cnt_q == BAD_W'(`DLX_LOSE_BAD - 1)) begin
                     good_cnt_q <= '0;
                     state_q    <= LOCK_HUNT;   // lost it, hunt from scratch
                  end else begin
                     bad_cnt_q <= bad_cnt_q + 1'b1;
                  end
               end
               default: state_q <= LOCK_HUNT;
            endcase
         end
      end
   end

   // ------------------------------------------------------------
   // control block detect
   always_ff @(posedge opt_gckn or negedge arst_n) begin
      if (!arst_n) begin
         pattern_sync <= 1'b0;
         pattern_ts1  <= 1'b0;
      end else begin
         pattern_sync <= ctl_locked && (beat.payload[7:0] == CTL_SYNC);
         pattern_ts1  <= ctl_locked && (beat.payload[7:0] == CTL_TS1);
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dlx_rx_lane_deskew.sv ====
/*
  per-lane deskew fifo
  arms on the first deskew marker while all lanes are locked and training
  skew between lanes shows up as occupancy, flush empties and disarms
*/
`include "dlx_rx_defs.svh"
`default_nettype none

module dlx_rx_lane_deskew (
   input  wire                             opt_gckn,
   input  wire                             arst_n,
   input  wire                             beat_valid,
   input  wire dlx_lane_pkg::lane_beat_t   beat,
   input  wire                             all_locked,
   input  wire                             training,
   input  wire                             fifo_pop,      // joint read from main
   input  wire                             deskew_flush,
   output logic                            fifo_empty,
   output logic                            overflow,
   output dlx_lane_pkg::lane_beat_t        fifo_head
);
   import dlx_lane_pkg::*;

   localparam int PTR_W = $clog2(`DLX_DESKEW_DEPTH);
   localparam int CNT_W = PTR_W + 1;

   lane_beat_t       mem [`DLX_DESKEW_DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             armed_q;
   logic             is_marker;
   logic             arm_now;
   logic             wr_req;
   logic             wr_en;
   logic             rd_en;
   logic             full;

   assign is_marker = beat_valid && (beat.hdr == HDR_CTL) &&
                      (beat.payload[7:0] == CTL_DESKEW);
   assign arm_now   = !armed_q && all_locked && training && is_marker;
   assign wr_req    = (armed_q && beat_valid) || arm_now;   // marker itself goes in

   assign full       = (count_q == CNT_W'(`DLX_DESKEW_DEPTH));
   assign fifo_empty = (count_q == '0);
   assign rd_en      = fifo_pop && !fifo_empty;
   assign wr_en      = wr_req && (!full || rd_en);          // pop frees a slot
   assign overflow   = wr_req && full && !rd_en;
   assign fifo_head  = mem[rd_ptr_q];

   // ------------------------------------------------------------
   // pointers, count, arm flag
   always_ff @(posedge opt_gckn or negedge arst_n) begin
      if (!arst_n) begin
         armed_q  <= 1'b0;
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else if (deskew_flush) begin
         armed_q  <= 1'b0;                      // wait for next marker
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (arm_now) begin
            armed_q <= 1'b1;
         end
         if (wr_en) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (rd_en) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({wr_en, rd_en})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;       // both or neither
         endcase
      end
   end

   // storage
   always_ff @(posedge opt_gckn) begin
      if (wr_en) begin
         mem[wr_ptr_q] <= beat;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dlx_rx_main.sv ====
/*
  joint fifo read, deskew check, link state and flit assembly
  heads are popped together once every lane has something
  no back-pressure, flit consumer takes every flit_valid
*/
`include "dlx_rx_defs.svh"
`default_nettype none

module dlx_rx_main (
   input  wire                                           opt_gckn,
   input  wire                                           arst_n,
   input  wire                                           training,
   input  wire                                           all_locked,
   input  wire [`DLX_LANES-1:0]                          fifo_empty,
   input  wire [`DLX_LANES-1:0]                          overflow,
   input  wire dlx_lane_pkg::lane_beat_t [`DLX_LANES-1:0] fifo_head,
   output logic                                          fifo_pop,
   output logic                                          deskew_flush,
   output logic                                          deskew_done,
   output logic                                          link_up,
   output logic                                          flit_valid,
   output dlx_link_pkg::flit_t                           flit
);
   import dlx_lane_pkg::*;
   import dlx_link_pkg::*;

   localparam int BEAT_BITS = `DLX_FLIT_BITS / `DLX_FLIT_BEATS;
   localparam int IDX_W     = $clog2(`DLX_FLIT_BEATS);

   link_state_e      state_q;
   link_state_e      state_d;
   logic [IDX_W-1:0] beat_idx_q;   // which half of the flit is next
   logic             heads_marker;
   logic             heads_data;
   logic             misaligned;
   logic             pop_data;
   logic             last_beat;

   // ------------------------------------------------------------
   // head classification across lanes
   always_comb begin
      heads_marker = 1'b1;
      heads_data   = 1'b1;
      for (int n = 0; n < `DLX_LANES; n++) begin
         heads_marker &= (fifo_head[n].hdr == HDR_CTL) &&
                         (fifo_head[n].payload[7:0] == CTL_DESKEW);
         heads_data   &= (fifo_head[n].hdr == HDR_DATA);
      end
   end

   assign fifo_pop     = &(~fifo_empty);               // every lane has a beat
   assign misaligned   = fifo_pop && !deskew_done && !heads_marker;
   assign deskew_flush = !all_locked || (|overflow) || misaligned;

   assign deskew_done = (state_q == LINK_ALIGNED) || (state_q == LINK_UP);
   assign link_up     = (state_q == LINK_UP);

   // ------------------------------------------------------------
   // link state
   always_comb begin
      state_d = state_q;
      if (!all_locked) begin
         state_d = LINK_DOWN;
      end else if (|overflow) begin
         state_d = LINK_DESKEW;                        // lanes flushed, start over
      end else begin
         case (state_q)
            LINK_DOWN, LINK_DESKEW: begin
               if (fifo_pop && heads_marker) begin
                  state_d = LINK_ALIGNED;
               end else begin
                  state_d = LINK_DESKEW;
               end
            end
            LINK_ALIGNED: if (!training) state_d = LINK_UP;
            LINK_UP:      if (training) state_d = LINK_ALIGNED;
            default:      state_d = LINK_DOWN;
         endcase
      end
   end

   // data beats only count once the link is up, control beats drop out
   assign pop_data  = fifo_pop && heads_data && (state_q == LINK_UP);
   assign last_beat = (beat_idx_q == IDX_W'(`DLX_FLIT_BEATS - 1));

   always_ff @(posedge opt_gckn or negedge arst_n) begin
      if (!arst_n) begin
         state_q    <= LINK_DOWN;
         beat_idx_q <= '0;
         flit_valid <= 1'b0;
      end else begin
         state_q    <= state_d;
         // no flit out on the edge the link drops
         flit_valid <= pop_data && last_beat && (state_d == LINK_UP);
         if (state_q != LINK_UP) begin
            beat_idx_q <= '0;
         end else if (pop_data) begin
            beat_idx_q <= last_beat ? '0 : beat_idx_q + 1'b1;
         end
      end
   end

   // ------------------------------------------------------------
   // flit assembly, lane n to bits n*64 of the current beat
   always_ff @(posedge opt_gckn) begin
      if (pop_data) begin
         for (int n = 0; n < `DLX_LANES; n++) begin
            flit[beat_idx_q * BEAT_BITS + n * `DLX_BLOCK_BITS +: `DLX_BLOCK_BITS]
               <= fifo_head[n].payload;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dlx_rx_top.sv ====
/*
  receive side of the serial link, 4 lanes
  rx_valid low on any lane stalls the joint read for all of them
  training is a level from the transmit side
*/
`include "dlx_rx_defs.svh"
`default_nettype none

module dlx_rx_top (
   input  wire                                          opt_gckn,
   input  wire                                          arst_n,
   input  wire [`DLX_LANES-1:0]                         rx_valid,
   input  wire [`DLX_LANES-1:0][`DLX_HDR_BITS-1:0]      rx_header,
   input  wire [`DLX_LANES-1:0][`DLX_BLOCK_BITS-1:0]    rx_data,
   input  wire                                          training,
   output logic [`DLX_LANES-1:0]                        rx_slip,
   output logic [`DLX_LANES-1:0]                        block_lock,
   output logic [`DLX_LANES-1:0]                        pattern_sync,
   output logic [`DLX_LANES-1:0]                        pattern_ts1,
   output logic                                         deskew_done,
   output logic                                         link_up,
   output logic                                         flit_valid,
   output dlx_link_pkg::flit_t                          flit
);
   import dlx_lane_pkg::*;

   logic [`DLX_LANES-1:0]      beat_valid;   // lock stage to fifo
   lane_beat_t [`DLX_LANES-1:0] beat;
   logic [`DLX_LANES-1:0]      fifo_empty;
   logic [`DLX_LANES-1:0]      overflow;
   lane_beat_t [`DLX_LANES-1:0] fifo_head;
   logic                       all_locked;
   logic                       fifo_pop;
   logic                       deskew_flush;

   // deskew may only start with every lane aligned
   assign all_locked = &block_lock;

   // ------------------------------------------------------------
   // per-lane lock and fifo
   for (genvar n = 0; n < `DLX_LANES; n++) begin : g_lane
      dlx_rx_block_lock u_lock (
         .opt_gckn     (opt_gckn),
         .arst_n       (arst_n),
         .rx_valid     (rx_valid[n]),
         .rx_header    (rx_header[n]),
         .rx_data      (rx_data[n]),
         .rx_slip      (rx_slip[n]),
         .lock         (block_lock[n]),
         .pattern_sync (pattern_sync[n]),
         .pattern_ts1  (pattern_ts1[n]),
         .beat_valid   (beat_valid[n]),
         .beat         (beat[n])
      );

      dlx_rx_lane_deskew u_deskew (
         .opt_gckn     (opt_gckn),
         .arst_n       (arst_n),
         .beat_valid   (beat_valid[n]),
         .beat         (beat[n]),
         .all_locked   (all_locked),
         .training     (training),
         .fifo_pop     (fifo_pop),      // common to all lanes
         .deskew_flush (deskew_flush),
         .fifo_empty   (fifo_empty[n]),
         .overflow     (overflow[n]),
         .fifo_head    (fifo_head[n])
      );
   end

   // link level
   dlx_rx_main u_main (
      .opt_gckn     (opt_gckn),
      .arst_n       (arst_n),
      .training     (training),
      .all_locked   (all_locked),
      .fifo_empty   (fifo_empty),
      .overflow     (overflow),
      .fifo_head    (fifo_head),
      .fifo_pop     (fifo_pop),
      .deskew_flush (deskew_flush),
      .deskew_done  (deskew_done),
      .link_up      (link_up),
      .flit_valid   (flit_valid),
      .flit         (flit)
   );

endmodule

`default_nettype wire

// ==== verification/dlx_rx_clkgen.sv ====
/*
  free running testbench clock, 100 ns period
  starts low, first rising edge half a period in
*/
`default_nettype none

module dlx_rx_clkgen #(
   parameter int PERIOD_NS = 100
) (
   output logic opt_gckn
);
   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      opt_gckn = 1'b0;
      forever begin
         #(PERIOD_NS / 2) opt_gckn = ~opt_gckn;   // half period per phase
      end
   end

endmodule

`default_nettype wire

// ==== verification/dlx_rx_props.sv ====
/*
  concurrent checks on the receive top, bound in from the testbench
  every property is off while arst_n is low
*/
`include "dlx_rx_defs.svh"
`default_nettype none

module dlx_rx_props (
   input wire                    opt_gckn,
   input wire                    arst_n,
   input wire [`DLX_LANES-1:0]   rx_slip,
   input wire [`DLX_LANES-1:0]   block_lock,
   input wire                    deskew_done,
   input wire                    link_up,
   input wire                    flit_valid
);
   timeunit 1ns;
   timeprecision 1ps;

   // gearbox slips only while a lane hunts
   for (genvar n = 0; n < `DLX_LANES; n++) begin : g_lane
      a_slip_unlocked: assert property (
         @(posedge opt_gckn) disable iff (!arst_n) rx_slip[n] |-> !block_lock[n]
      ) else $error("rx_slip pulsed on locked lane %0d", n);
   end

   a_flit_link_up: assert property (
      @(posedge opt_gckn) disable iff (!arst_n) flit_valid |-> link_up
   ) else $error("flit_valid while link is down");

   // deskew_done follows the lock state one clock late
   a_deskew_locked: assert property (
      @(posedge opt_gckn) disable iff (!arst_n) !(&block_lock) |=> !deskew_done
   ) else $error("deskew_done held with a lane out of lock");

endmodule

`default_nettype wire

// ==== verification/dlx_rx_tb.sv ====
/*
  directed testbench for the 4-lane receive path
  all lanes follow one common row stream, each delayed by its own skew
  inputs change on the falling edge, outputs are sampled there as well
  control type 00 serves as a filler block that raises no pattern pulse
*/
`include "dlx_rx_defs.svh"
`default_nettype none

module dlx_rx_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import dlx_lane_pkg::*;

   localparam int LANES     = `DLX_LANES;
   localparam int BW        = `DLX_BLOCK_BITS;
   localparam int BEAT_BITS = `DLX_FLIT_BITS / `DLX_FLIT_BEATS;
   localparam int HIST      = 4096;           // row history, longer than the run
   localparam logic [7:0] CTL_IDLE = 8'h00;   // filler control type

   logic                                opt_gckn;
   logic                                arst_n;
   logic [LANES-1:0]                    rx_valid;
   logic [LANES-1:0][`DLX_HDR_BITS-1:0] rx_header;
   logic [LANES-1:0][BW-1:0]            rx_data;
   logic                                training;
   logic [LANES-1:0]                    rx_slip;
   logic [LANES-1:0]                    block_lock;
   logic [LANES-1:0]                    pattern_sync;
   logic [LANES-1:0]                    pattern_ts1;
   logic                                deskew_done;
   logic                                link_up;
   logic                                flit_valid;
   logic [`DLX_FLIT_BITS-1:0]           flit;

   int seed = 36646;
   int errors;
   int checks;
   int step;                                 // global row index
   int skew [LANES];                         // per-lane delay in rows
   int quota [LANES];                        // slips to see before good headers
   int bad_left [LANES];                     // forced bad headers still to send
   int slip_cnt [LANES];
   int sync_cnt [LANES];
   int ts1_cnt [LANES];
   int flit_cnt;
   logic [`DLX_HDR_BITS-1:0] hist_hdr [HIST];
   logic [BW-1:0]            hist_pay [HIST][LANES];
   logic [BW-1:0]            row_pay [LANES];         // row being built
   logic [BEAT_BITS-1:0]     beat_q [$];              // expected data beats

   dlx_rx_clkgen u_clk (.opt_gckn(opt_gckn));

   dlx_rx_top DUT (
      .opt_gckn     (opt_gckn),
      .arst_n       (arst_n),
      .rx_valid     (rx_valid),
      .rx_header    (rx_header),
      .rx_data      (rx_data),
      .training     (training),
      .rx_slip      (rx_slip),
      .block_lock   (block_lock),
      .pattern_sync (pattern_sync),
      .pattern_ts1  (pattern_ts1),
      .deskew_done  (deskew_done),
      .link_up      (link_up),
      .flit_valid   (flit_valid),
      .flit         (flit)
   );

   bind dlx_rx_top dlx_rx_props u_props (
      .opt_gckn    (opt_gckn),
      .arst_n      (arst_n),
      .rx_slip     (rx_slip),
      .block_lock  (block_lock),
      .deskew_done (deskew_done),
      .link_up     (link_up),
      .flit_valid  (flit_valid)
   );

   // ------------------------------------------------------------
   // reporting
   task automatic check(input string name, input logic [`DLX_FLIT_BITS-1:0] got,
                        input logic [`DLX_FLIT_BITS-1:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("ERROR t=%0t %s got %0h expected %0h", $time, name, got, exp);
      end
   endtask

   task automatic report_failure(input string what);
      errors++;
      $display("FAILURE t=%0t %s", $time, what);
   endtask

   task automatic test_line(input string name, input int err0);
      if (errors == err0) begin
         $display("test %-10s ok", name);
      end else begin
         $display("test %-10s %0d errors", name, errors - err0);
      end
   endtask

   task automatic clear_counts();
      for (int n = 0; n < LANES; n++) begin
         slip_cnt[n] = 0;
         sync_cnt[n] = 0;
         ts1_cnt[n]  = 0;
      end
      flit_cnt = 0;
   endtask

   // ------------------------------------------------------------
   // lane stimulus model
   // wait one clock, then collect what the last rising edge produced
   task automatic next_cycle();
      logic [`DLX_FLIT_BITS-1:0] exp;
      @(negedge opt_gckn);
      for (int n = 0; n < LANES; n++) begin
         slip_cnt[n] += int'(rx_slip[n]);
         sync_cnt[n] += int'(pattern_sync[n]);
         ts1_cnt[n]  += int'(pattern_ts1[n]);
      end
      if (flit_valid) begin
         if (beat_q.size() < 2) begin
            report_failure("flit_valid came with fewer than two data beats sent");
         end else begin
            exp = {beat_q[1], beat_q[0]};   // beat 0 in the low half
            void'(beat_q.pop_front());
            void'(beat_q.pop_front());
            check("flit", flit, exp);
            flit_cnt++;
         end
      end
   endtask

   // one row per clock, lane n sends the row skew[n] steps old
   task automatic send_row(input logic [`DLX_HDR_BITS-1:0] hdr);
      int idx;
      logic bad_bit;
      logic [BEAT_BITS-1:0] row;
      next_cycle();
      hist_hdr[step] = hdr;
      for (int n = 0; n < LANES; n++) begin
         hist_pay[step][n] = row_pay[n];
         row[n*BW +: BW]   = row_pay[n];       // lane n at n*64
      end
      if (hdr == HDR_DATA) begin
         beat_q.push_back(row);
      end
      for (int n = 0; n < LANES; n++) begin
         idx         = step - skew[n];
         rx_valid[n] = 1'b1;
         if (bad_left[n] > 0 || slip_cnt[n] < quota[n]) begin
            bad_bit      = $random(seed);
            rx_header[n] = {bad_bit, bad_bit};     // 00 or 11
            rx_data[n]   = {$random(seed), $random(seed)};
            if (bad_left[n] > 0) begin
               bad_left[n]--;
            end
         end else if (idx < 0) begin
            rx_header[n] = HDR_CTL;               // filler before the stream
            rx_data[n]   = {56'h0, CTL_IDLE};
         end else begin
            rx_header[n] = hist_hdr[idx];
            rx_data[n]   = hist_pay[idx][n];
         end
      end
      step++;
   endtask

   task automatic send_ctl_row(input logic [7:0] ctl);
      for (int n = 0; n < LANES; n++) begin
         row_pay[n] = {56'h0, ctl};
      end
      send_row(HDR_CTL);
   endtask

   // ------------------------------------------------------------
   // tests
   task automatic test_reset();
      int err0 = errors;
      arst_n = 1'b0;
      for (int i = 0; i < 10; i++) begin
         @(negedge opt_gckn);
      end
      arst_n = 1'b1;
      check("rx_slip", rx_slip, '0);
      check("block_lock", block_lock, '0);
      check("pattern_sync", pattern_sync, '0);
      check("pattern_ts1", pattern_ts1, '0);
      check("deskew_done", deskew_done, '0);
      check("link_up", link_up, '0);
      check("flit_valid", flit_valid, '0);
      test_line("reset", err0);
   endtask

   task automatic test_lock();
      int err0 = errors;
      int bad_runs [LANES];
      int t;
      clear_counts();
      for (int n = 0; n < LANES; n++) begin
         bad_runs[n] = $unsigned($random(seed)) % 6;
         quota[n]    = bad_runs[n];
      end
      t = 0;
      while (block_lock !== '1 && t < 400) begin
         send_ctl_row(CTL_IDLE);
         t++;
      end
      if (block_lock !== '1) begin
         report_failure("block_lock did not rise on every lane");
      end
      for (int i = 0; i < 40; i++) begin
         send_ctl_row(CTL_IDLE);               // slips must stay quiet now
      end
      for (int n = 0; n < LANES; n++) begin
         check($sformatf("rx_slip count lane %0d", n), slip_cnt[n], bad_runs[n]);
         quota[n] = 0;
      end
      check("block_lock", block_lock, {LANES{1'b1}});
      test_line("lock", err0);
   endtask

   task automatic test_patterns();
      int err0 = errors;
      int exp_sync [LANES];
      int exp_ts1 [LANES];
      int rows;
      int pick;
      clear_counts();
      for (int n = 0; n < LANES; n++) begin
         exp_sync[n] = 0;
         exp_ts1[n]  = 0;
      end
      rows = 10 + $unsigned($random(seed)) % 16;
      for (int r = 0; r < rows; r++) begin
         for (int n = 0; n < LANES; n++) begin
            pick = $unsigned($random(seed)) % 3;
            if (pick == 0) begin
               row_pay[n] = {56'h0, CTL_SYNC};
               exp_sync[n]++;
            end else if (pick == 1) begin
               row_pay[n] = {56'h0, CTL_TS1};
               exp_ts1[n]++;
            end else begin
               row_pay[n] = {56'h0, CTL_IDLE};
            end
         end
         send_row(HDR_CTL);
      end
      // pulses trail by two clocks, filler also covers later skew changes
      for (int i = 0; i < 12; i++) begin
         send_ctl_row(CTL_IDLE);
      end
      for (int n = 0; n < LANES; n++) begin
         check($sformatf("pattern_sync count lane %0d", n), sync_cnt[n], exp_sync[n]);
         check($sformatf("pattern_ts1 count lane %0d", n), ts1_cnt[n], exp_ts1[n]);
      end
      test_line("patterns", err0);
   endtask

   task automatic test_deskew();
      int err0 = errors;
      int t;
      for (int n = 0; n < LANES; n++) begin
         skew[n] = $unsigned($random(seed)) % (`DLX_DESKEW_DEPTH - 1);   // 0 to depth-2
      end
      send_ctl_row(CTL_DESKEW);
      t = 0;
      while (!deskew_done && t < 40) begin
         send_ctl_row(CTL_IDLE);
         t++;
      end
      if (!deskew_done) begin
         report_failure("deskew_done did not rise with skew inside the FIFO depth");
      end
      training = 1'b0;
      t = 0;
      while (!link_up && t < 10) begin
         send_ctl_row(CTL_IDLE);
         t++;
      end
      check("deskew_done", deskew_done, 1);
      check("link_up", link_up, 1);
      test_line("deskew", err0);
   endtask

   task automatic test_flit();
      int err0 = errors;
      int data_rows;
      int sent;
      int t;
      clear_counts();
      beat_q.delete();
      data_rows = 2 * (4 + $unsigned($random(seed)) % 5);
      sent = 0;
      while (sent < data_rows) begin
         if ($unsigned($random(seed)) % 4 == 0) begin
            send_ctl_row(CTL_SYNC);           // control rows drop out of flits
         end else begin
            for (int n = 0; n < LANES; n++) begin
               row_pay[n] = {$random(seed), $random(seed)};
            end
            send_row(HDR_DATA);
            sent++;
         end
      end
      t = 0;
      while (beat_q.size() > 0 && t < 40) begin
         send_ctl_row(CTL_IDLE);
         t++;
      end
      if (beat_q.size() > 0) begin
         report_failure("data beats were sent but no flit carried them");
      end
      check("flit count", flit_cnt, data_rows / 2);
      test_line("flit", err0);
   endtask

   task automatic test_lock_loss();
      int err0 = errors;
      int lane;
      int t;
      lane           = $unsigned($random(seed)) % LANES;
      bad_left[lane] = `DLX_LOSE_BAD;
      t = 0;
      while ((block_lock[lane] || deskew_done || link_up) && t < 20) begin
         send_ctl_row(CTL_IDLE);
         t++;
      end
      check($sformatf("block_lock[%0d]", lane), block_lock[lane], 0);
      check("deskew_done", deskew_done, 0);
      check("link_up", link_up, 0);
      test_line("lock_loss", err0);
   endtask

   // relock after the loss, then a skew the FIFOs cannot absorb
   task automatic test_overflow();
      int err0 = errors;
      int late;
      int t;
      training = 1'b1;
      t = 0;
      while (block_lock !== '1 && t < 100) begin
         send_ctl_row(CTL_IDLE);
         t++;
      end
      if (block_lock !== '1) begin
         report_failure("lane did not relock after the lock loss");
      end
      late = $unsigned($random(seed)) % LANES;
      for (int n = 0; n < LANES; n++) begin
         skew[n] = (n == late) ? `DLX_DESKEW_DEPTH + 2 : 0;
      end
      send_ctl_row(CTL_DESKEW);
      t = 0;
      while (!deskew_done && t < 60) begin   // running out is the expected end
         send_ctl_row(CTL_IDLE);
         t++;
      end
      check("deskew_done", deskew_done, 0);
      test_line("overflow", err0);
   endtask

   // ------------------------------------------------------------
   initial begin
      arst_n    = 1'b0;
      training  = 1'b1;
      rx_valid  = '0;
      rx_header = '0;
      rx_data   = '0;
      errors    = 0;
      checks    = 0;
      step      = 0;
      for (int n = 0; n < LANES; n++) begin
         skew[n]     = 0;
         quota[n]    = 0;
         bad_left[n] = 0;
         row_pay[n]  = '0;
      end
      clear_counts();

      test_reset();
      test_lock();
      test_patterns();
      test_deskew();
      test_flit();
      test_lock_loss();
      test_overflow();

      $display("tests=7 checks=%0d errors=%0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+rtl
rtl/dlx_lane_pkg.sv
rtl/dlx_link_pkg.sv
rtl/dlx_rx_block_lock.sv
rtl/dlx_rx_lane_deskew.sv
rtl/dlx_rx_main.sv
rtl/dlx_rx_top.sv
verification/dlx_rx_clkgen.sv
verification/dlx_rx_props.sv
verification/dlx_rx_tb.sv

// ==== Makefile ====
# Verilator build and run of the receive link testbench
# override any variable on the command line, e.g. make test TOP=dlx_rx_tb

VERILATOR ?= verilator
TOP       ?= dlx_rx_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= Testbench passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR FLAGS PASS_MSG"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
